//--- rtl/jtag_pkg.sv
package jtag_pkg;

    //////////////////////////////////////////////////////////////////////
    // Register lengths and fixed values
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned IR_WIDTH     = 4;     // Instruction register length
    localparam int unsigned IDCODE_WIDTH = 32;    // Device identification length

    // Fixed pattern loaded in CAPTURE_IR, LSB pair 01 per JTAG
    localparam logic [IR_WIDTH-1:0]     IR_CAPTURE     = 4'b0001;
    localparam logic [IDCODE_WIDTH-1:0] DEFAULT_IDCODE = 32'hDEAD104D; // LSB must be 1

    //////////////////////////////////////////////////////////////////////
    // TAP controller states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'b0000,
        RUN_TEST_IDLE    = 4'b0001,
        SELECT_DR_SCAN   = 4'b0010,
        CAPTURE_DR       = 4'b0011,
        SHIFT_DR         = 4'b0100,
        EXIT1_DR         = 4'b0101,
        PAUSE_DR         = 4'b0110,
        EXIT2_DR         = 4'b0111,
        UPDATE_DR        = 4'b1000,
        SELECT_IR_SCAN   = 4'b1001,   // IR column starts here
        CAPTURE_IR       = 4'b1010,
        SHIFT_IR         = 4'b1011,
        EXIT1_IR         = 4'b1100,
        PAUSE_IR         = 4'b1101,
        EXIT2_IR         = 4'b1110,
        UPDATE_IR        = 4'b1111
    } tap_state_e;

    // Instruction codes, anything else behaves as BYPASS
    typedef enum logic [IR_WIDTH-1:0] {
        SAMPLE_PRELOAD = 4'b0001,
        EXTEST         = 4'b0010,
        INTEST         = 4'b0011,
        IDCODE         = 4'b0100,
        BYPASS         = 4'b1111    // All ones as required by the standard
    } ir_opcode_e;

    // Data register placed between TDI and TDO
    typedef enum logic [1:0] {
        DR_BYPASS = 2'b00,
        DR_IDCODE = 2'b01,
        DR_BSR    = 2'b10
    } dr_select_e;

    // Pin routing through the boundary cells
    typedef enum logic [1:0] {
        BSR_NORMAL = 2'b00,         // Functional path, cells only observe
        BSR_EXTEST = 2'b01,         // Hold cells drive the system pins
        BSR_INTEST = 2'b10          // Hold cells drive the core inputs
    } bsr_mode_e;

endpackage

//--- rtl/tap_controller.sv
`timescale 1ns/1ps

module tap_controller (
    input  logic TCK,
    input  logic rst,
    input  logic tms,
    output logic capture_dr,
    output logic shift_dr,
    output logic update_dr,
    output logic capture_ir,
    output logic shift_ir,
    output logic update_ir,
    output logic test_logic_reset
);

    jtag_pkg::tap_state_e state;       // Current TAP state
    jtag_pkg::tap_state_e next_state;

    //////////////////////////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge TCK) begin
        if (rst) begin
            state <= jtag_pkg::TEST_LOGIC_RESET;
        end else begin
            state <= next_state;        // One step per edge, TMS decides
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Transition table
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            jtag_pkg::TEST_LOGIC_RESET:
                next_state = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::RUN_TEST_IDLE:
                next_state = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::SELECT_DR_SCAN:
                next_state = tms ? jtag_pkg::SELECT_IR_SCAN : jtag_pkg::CAPTURE_DR;
            jtag_pkg::CAPTURE_DR:
                next_state = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::SHIFT_DR:
                next_state = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::EXIT1_DR:
                next_state = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
            jtag_pkg::PAUSE_DR:
                next_state = tms ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
            jtag_pkg::EXIT2_DR:
                next_state = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR; // Resume shift
            jtag_pkg::UPDATE_DR:
                next_state = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::SELECT_IR_SCAN:
                next_state = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::CAPTURE_IR;
            jtag_pkg::CAPTURE_IR:
                next_state = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::SHIFT_IR:
                next_state = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::EXIT1_IR:
                next_state = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
            jtag_pkg::PAUSE_IR:
                next_state = tms ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
            jtag_pkg::EXIT2_IR:
                next_state = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::UPDATE_IR:
                next_state = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
            default:
                next_state = jtag_pkg::TEST_LOGIC_RESET;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Strobes, high for the whole cycle spent in the state
    //////////////////////////////////////////////////////////////////////

    // Registers act on the edge that leaves the state
    assign capture_dr = (state == jtag_pkg::CAPTURE_DR);
    assign shift_dr   = (state == jtag_pkg::SHIFT_DR);
    assign update_dr  = (state == jtag_pkg::UPDATE_DR);
    assign capture_ir = (state == jtag_pkg::CAPTURE_IR);
    assign shift_ir   = (state == jtag_pkg::SHIFT_IR);
    assign update_ir  = (state == jtag_pkg::UPDATE_IR);

    assign test_logic_reset = (state == jtag_pkg::TEST_LOGIC_RESET); // IR reload request

endmodule

//--- rtl/instruction_register.sv
`timescale 1ns/1ps

module instruction_register (
    input  logic                 TCK,
    input  logic                 rst,
    input  logic                 tdi,
    input  logic                 capture_ir,
    input  logic                 shift_ir,
    input  logic                 update_ir,
    input  logic                 test_logic_reset,
    output jtag_pkg::dr_select_e dr_select,
    output jtag_pkg::bsr_mode_e  bsr_mode,
    output logic                 ir_tdo
);

    logic [jtag_pkg::IR_WIDTH-1:0] ir_shift;   // Scan path side
    jtag_pkg::ir_opcode_e          ir_hold;    // Active instruction

    //////////////////////////////////////////////////////////////////////
    // Shift stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge TCK) begin
        if (capture_ir) begin
            ir_shift <= jtag_pkg::IR_CAPTURE;
        end else if (shift_ir) begin
            ir_shift <= {tdi, ir_shift[jtag_pkg::IR_WIDTH-1:1]}; // TDI in at MSB
        end
    end

    assign ir_tdo = ir_shift[0];

    // Hold stage, IDCODE is the power-on and TLR instruction
    always_ff @(posedge TCK) begin
        if (rst || test_logic_reset) begin
            ir_hold <= jtag_pkg::IDCODE;
        end else if (update_ir) begin
            ir_hold <= jtag_pkg::ir_opcode_e'(ir_shift); // Undefined codes kept as is
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dr_select = jtag_pkg::DR_BYPASS;   // BYPASS and every unknown code
        bsr_mode  = jtag_pkg::BSR_NORMAL;
        case (ir_hold)
            jtag_pkg::IDCODE: begin
                dr_select = jtag_pkg::DR_IDCODE;
            end
            jtag_pkg::SAMPLE_PRELOAD: begin
                dr_select = jtag_pkg::DR_BSR;   // Pins stay functional
            end
            jtag_pkg::EXTEST: begin
                dr_select = jtag_pkg::DR_BSR;
                bsr_mode  = jtag_pkg::BSR_EXTEST;
            end
            jtag_pkg::INTEST: begin
                dr_select = jtag_pkg::DR_BSR;
                bsr_mode  = jtag_pkg::BSR_INTEST;
            end
            default: begin
                dr_select = jtag_pkg::DR_BYPASS;
                bsr_mode  = jtag_pkg::BSR_NORMAL;
            end
        endcase
    end

endmodule

//--- rtl/boundary_scan_register.sv
`timescale 1ns/1ps

module boundary_scan_register #(
    parameter int unsigned INPUT_WIDTH  = 5,
    parameter int unsigned OUTPUT_WIDTH = 4
) (
    input  logic                    TCK,
    input  logic                    rst,
    input  logic                    tdi,
    input  logic                    capture_dr,
    input  logic                    shift_dr,
    input  logic                    update_dr,
    input  jtag_pkg::dr_select_e    dr_select,
    input  jtag_pkg::bsr_mode_e     bsr_mode,
    input  logic [INPUT_WIDTH-1:0]  sys_in,
    input  logic [OUTPUT_WIDTH-1:0] core_out,
    output logic [INPUT_WIDTH-1:0]  core_in,
    output logic [OUTPUT_WIDTH-1:0] sys_out,
    output logic                    bsr_tdo
);

    localparam int unsigned TOTAL_WIDTH = INPUT_WIDTH + OUTPUT_WIDTH;

    // Upper cells are input cells, lower cells are output cells
    logic [TOTAL_WIDTH-1:0] bsr_shift;
    logic [TOTAL_WIDTH-1:0] bsr_hold;
    logic                   bsr_active;    // BSR sits in the scan path

    assign bsr_active = (dr_select == jtag_pkg::DR_BSR);

    //////////////////////////////////////////////////////////////////////
    // Capture, shift and update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge TCK) begin
        if (rst) begin
            bsr_shift <= '0;
            bsr_hold  <= '0;
        end else begin
            if (bsr_active && capture_dr) begin
                bsr_shift <= {sys_in, core_out};   // Snapshot of both pin groups
            end else if (bsr_active && shift_dr) begin
                bsr_shift <= {tdi, bsr_shift[TOTAL_WIDTH-1:1]};
            end

            // Hold cells only change in UPDATE_DR
            if (bsr_active && update_dr) begin
                bsr_hold <= bsr_shift;
            end
        end
    end

    assign bsr_tdo = bsr_shift[0];

    //////////////////////////////////////////////////////////////////////
    // Pin muxing
    //////////////////////////////////////////////////////////////////////

    // INTEST drives the core from the input hold cells
    assign core_in = (bsr_mode == jtag_pkg::BSR_INTEST) ?
                     bsr_hold[TOTAL_WIDTH-1:OUTPUT_WIDTH] : sys_in;

    // EXTEST drives the board from the output hold cells
    assign sys_out = (bsr_mode == jtag_pkg::BSR_EXTEST) ?
                     bsr_hold[OUTPUT_WIDTH-1:0] : core_out;

endmodule

//--- rtl/idcode_bypass_tdo.sv
`timescale 1ns/1ps

module idcode_bypass_tdo #(
    parameter logic [jtag_pkg::IDCODE_WIDTH-1:0] IDCODE_VALUE = jtag_pkg::DEFAULT_IDCODE
) (
    input  logic                 TCK,
    input  logic                 rst,
    input  logic                 tdi,
    input  logic                 capture_dr,
    input  logic                 shift_dr,
    input  logic                 shift_ir,
    input  logic                 ir_tdo,
    input  logic                 bsr_tdo,
    input  jtag_pkg::dr_select_e dr_select,
    output logic                 tdo,
    output logic                 tdo_en
);

    logic [jtag_pkg::IDCODE_WIDTH-1:0] id_shift;
    logic                              bypass_cell;   // Single bit path

    //////////////////////////////////////////////////////////////////////
    // Identification and bypass registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge TCK) begin
        if (rst) begin
            id_shift    <= IDCODE_VALUE;
            bypass_cell <= 1'b0;
        end else begin
            if (dr_select == jtag_pkg::DR_IDCODE) begin
                if (capture_dr) begin
                    id_shift <= IDCODE_VALUE;
                end else if (shift_dr) begin
                    id_shift <= {1'b1, id_shift[jtag_pkg::IDCODE_WIDTH-1:1]}; // Fill with ones
                end
            end
            if (dr_select == jtag_pkg::DR_BYPASS) begin
                if (capture_dr) begin
                    bypass_cell <= 1'b0;       // Known zero leads the bypassed stream
                end else if (shift_dr) begin
                    bypass_cell <= tdi;
                end
            end
        end
    end

    // TDO source, driven only while a shift state is active
    always_comb begin
        tdo_en = shift_dr | shift_ir;
        tdo    = 1'b0;
        if (shift_ir) begin
            tdo = ir_tdo;
        end else if (shift_dr) begin
            case (dr_select)
                jtag_pkg::DR_IDCODE: tdo = id_shift[0];
                jtag_pkg::DR_BSR:    tdo = bsr_tdo;
                default:             tdo = bypass_cell;
            endcase
        end
    end

endmodule

//--- rtl/jtag_tap_top.sv
`timescale 1ns/1ps

module jtag_tap_top #(
    parameter int unsigned                       INPUT_WIDTH  = 5,
    parameter int unsigned                       OUTPUT_WIDTH = 4,
    parameter logic [jtag_pkg::IDCODE_WIDTH-1:0] IDCODE_VALUE = jtag_pkg::DEFAULT_IDCODE
) (
    input  logic                    TCK,
    input  logic                    rst,
    input  logic                    tms,
    input  logic                    tdi,
    input  logic [INPUT_WIDTH-1:0]  sys_in,
    input  logic [OUTPUT_WIDTH-1:0] core_out,
    output logic [INPUT_WIDTH-1:0]  core_in,
    output logic [OUTPUT_WIDTH-1:0] sys_out,
    output logic                    tdo,
    output logic                    tdo_en
);

    logic                 capture_dr;
    logic                 shift_dr;
    logic                 update_dr;
    logic                 capture_ir;
    logic                 shift_ir;
    logic                 update_ir;
    logic                 test_logic_reset;
    jtag_pkg::dr_select_e dr_select;     // Decoded from active instruction
    jtag_pkg::bsr_mode_e  bsr_mode;
    logic                 ir_tdo;
    logic                 bsr_tdo;

    //////////////////////////////////////////////////////////////////////
    // Decode side
    //////////////////////////////////////////////////////////////////////

    tap_controller i_tap_controller (
        .TCK              (TCK),
        .rst              (rst),
        .tms              (tms),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .capture_ir       (capture_ir),
        .shift_ir         (shift_ir),
        .update_ir        (update_ir),
        .test_logic_reset (test_logic_reset)
    );

    instruction_register i_instruction_register (
        .TCK              (TCK),
        .rst              (rst),
        .tdi              (tdi),
        .capture_ir       (capture_ir),
        .shift_ir         (shift_ir),
        .update_ir        (update_ir),
        .test_logic_reset (test_logic_reset),
        .dr_select        (dr_select),
        .bsr_mode         (bsr_mode),
        .ir_tdo           (ir_tdo)
    );

    // Boundary cells around the core pins
    boundary_scan_register #(
        .INPUT_WIDTH  (INPUT_WIDTH),
        .OUTPUT_WIDTH (OUTPUT_WIDTH)
    ) i_boundary_scan_register (
        .TCK        (TCK),
        .rst        (rst),
        .tdi        (tdi),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .dr_select  (dr_select),
        .bsr_mode   (bsr_mode),
        .sys_in     (sys_in),
        .core_out   (core_out),
        .core_in    (core_in),
        .sys_out    (sys_out),
        .bsr_tdo    (bsr_tdo)
    );

    idcode_bypass_tdo #(
        .IDCODE_VALUE (IDCODE_VALUE)
    ) i_idcode_bypass_tdo (
        .TCK        (TCK),
        .rst        (rst),
        .tdi        (tdi),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .shift_ir   (shift_ir),
        .ir_tdo     (ir_tdo),
        .bsr_tdo    (bsr_tdo),
        .dr_select  (dr_select),
        .tdo        (tdo),
        .tdo_en     (tdo_en)      // Stands in for the tri-state enable
    );

endmodule

//--- verification/jtag_tb_tasks.svh
`ifndef JTAG_TB_TASKS_SVH
`define JTAG_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Compare tasks, one per result type
//////////////////////////////////////////////////////////////////////

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
endtask

task automatic check_word(input string name, input logic [jtag_pkg::IDCODE_WIDTH-1:0] got,
                          input logic [jtag_pkg::IDCODE_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
endtask

task automatic check_core_in(input logic [IN_W-1:0] got, input logic [IN_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL t=%0t core_in got=%b exp=%b", $time, got, exp);
    end
endtask

task automatic check_sys_out(input logic [OUT_W-1:0] got, input logic [OUT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL t=%0t sys_out got=%b exp=%b", $time, got, exp);
    end
endtask

task automatic check_opcode(input string name, input jtag_pkg::ir_opcode_e got,
                            input jtag_pkg::ir_opcode_e exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
endtask

//////////////////////////////////////////////////////////////////////
// TAP navigation
//////////////////////////////////////////////////////////////////////

// One TCK cycle, drive on the falling edge and sample just before the rise
task automatic clock_step(input logic tms_v, input logic tdi_v,
                          output logic tdo_v, output logic en_v);
    @(negedge TCK);
    tms = tms_v;
    tdi = tdi_v;
    #(CLK_PERIOD/2 - 1);
    tdo_v = tdo;
    en_v  = tdo_en;
    @(posedge TCK);
endtask

task automatic step_checked(input logic tms_v, input logic tdi_v, input logic exp_en,
                            output logic tdo_v);
    logic en_v;
    clock_step(tms_v, tdi_v, tdo_v, en_v);
    check_bit("tdo_en", en_v, exp_en);
    if (!exp_en) begin
        check_bit("tdo", tdo_v, 1'b0);      // Parked low outside shift
    end
endtask

// Five TMS ones from anywhere, then park in RUN_TEST_IDLE
task automatic goto_reset();
    logic tdo_v;
    logic en_v;
    repeat (5) clock_step(1'b1, 1'b0, tdo_v, en_v);
    step_checked(1'b0, 1'b0, 1'b0, tdo_v);   // TLR to RTI
endtask

task automatic scan_ir(input jtag_pkg::ir_opcode_e op,
                       output logic [jtag_pkg::IR_WIDTH-1:0] captured);
    logic                          bit_v;
    logic [jtag_pkg::IR_WIDTH-1:0] op_bits;
    op_bits = op;
    step_checked(1'b1, 1'b0, 1'b0, bit_v);   // RTI to SELECT_DR_SCAN
    step_checked(1'b1, 1'b0, 1'b0, bit_v);   // To SELECT_IR_SCAN
    step_checked(1'b0, 1'b0, 1'b0, bit_v);   // To CAPTURE_IR
    step_checked(1'b0, 1'b0, 1'b0, bit_v);   // Capture edge leads into SHIFT_IR
    for (int i = 0; i < int'(jtag_pkg::IR_WIDTH); i++) begin
        step_checked(i == int'(jtag_pkg::IR_WIDTH) - 1, op_bits[i], 1'b1, bit_v);
        captured[i] = bit_v;                 // LSB first
    end
    step_checked(1'b1, 1'b0, 1'b0, bit_v);   // EXIT1_IR to UPDATE_IR
    step_checked(1'b0, 1'b0, 1'b0, bit_v);   // Update edge, back in RTI
endtask

task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
    logic bit_v;
    dout = '0;
    step_checked(1'b1, 1'b0, 1'b0, bit_v);   // RTI to SELECT_DR_SCAN
    step_checked(1'b0, 1'b0, 1'b0, bit_v);   // To CAPTURE_DR
    step_checked(1'b0, 1'b0, 1'b0, bit_v);   // Capture edge leads into SHIFT_DR
    for (int i = 0; i < len; i++) begin
        step_checked(i == len - 1, din[i], 1'b1, bit_v);
        dout[i] = bit_v;
    end
    step_checked(1'b1, 1'b0, 1'b0, bit_v);   // EXIT1_DR to UPDATE_DR
    step_checked(1'b0, 1'b0, 1'b0, bit_v);   // Hold cells load on this edge
endtask

`endif

//--- verification/tb_jtag_tap.sv
`timescale 1ns/1ps

module tb_jtag_tap;

    localparam int IN_W          = 5;
    localparam int OUT_W         = 4;
    localparam int BSR_W         = IN_W + OUT_W;
    localparam int CLK_PERIOD    = 10;
    localparam int PLANNED_SCANS = 16;      // Fifteen scans plus the abandoned shift
    localparam int SCAN_CYCLES   = 80;      // Budget per scan

    typedef enum {SCAN_IR, SCAN_IDCODE, SCAN_BYPASS, SCAN_BSR} scan_kind_e;

    logic             TCK;
    logic             rst;
    logic             tms;
    logic             tdi;
    logic [IN_W-1:0]  sys_in;
    logic [OUT_W-1:0] core_out;
    logic [IN_W-1:0]  core_in;
    logic [OUT_W-1:0] sys_out;
    logic             tdo;
    logic             tdo_en;

    int checks         = 0;
    int errors         = 0;
    int seed           = 58;
    int scans_issued   = 0;
    int scans_compared = 0;

    // Last finished scan, handed to the compare process
    scan_kind_e       cur_kind;
    int               cur_len;
    logic [63:0]      cur_din;
    logic [63:0]      cur_dout;
    logic [BSR_W-1:0] bsr_snap;            // Pins seen by the next capture
    event             scan_done;

    jtag_tap_top #(
        .INPUT_WIDTH  (IN_W),
        .OUTPUT_WIDTH (OUT_W),
        .IDCODE_VALUE (jtag_pkg::DEFAULT_IDCODE)
    ) i_dut (
        .TCK      (TCK),
        .rst      (rst),
        .tms      (tms),
        .tdi      (tdi),
        .sys_in   (sys_in),
        .core_out (core_out),
        .core_in  (core_in),
        .sys_out  (sys_out),
        .tdo      (tdo),
        .tdo_en   (tdo_en)
    );

    `include "jtag_tb_tasks.svh"

    initial begin
        TCK = 1'b0;
        forever #(CLK_PERIOD/2) TCK = ~TCK;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and compare
    //////////////////////////////////////////////////////////////////////

    // Expected TDO stream, bit i is the i-th bit out
    function automatic logic [63:0] expected_scan(input scan_kind_e kind, input int len,
                                                  input logic [63:0] din,
                                                  input logic [BSR_W-1:0] snap);
        logic [63:0] exp;
        exp = '0;
        case (kind)
            SCAN_IR:     exp[jtag_pkg::IR_WIDTH-1:0] = jtag_pkg::IR_CAPTURE;
            SCAN_IDCODE: exp = {{(64-jtag_pkg::IDCODE_WIDTH){1'b1}}, jtag_pkg::DEFAULT_IDCODE};
            SCAN_BYPASS: exp = {din[62:0], 1'b0};      // Leading zero then TDI one late
            SCAN_BSR:    exp = {din[63-BSR_W:0], snap}; // Captured pins first
            default:     exp = '0;
        endcase
        for (int i = len; i < 64; i++) begin
            exp[i] = 1'b0;
        end
        return exp;
    endfunction

    initial begin : compare_scans
        logic [63:0] exp;
        forever begin
            @(scan_done);
            exp = expected_scan(cur_kind, cur_len, cur_din, bsr_snap);
            scans_compared++;
            if (cur_kind == SCAN_IR) begin
                check_opcode("ir_capture", jtag_pkg::ir_opcode_e'(cur_dout[3:0]),
                             jtag_pkg::ir_opcode_e'(exp[3:0]));
            end else begin
                check_word($sformatf("tdo %s", cur_kind.name()),
                           cur_dout[jtag_pkg::IDCODE_WIDTH-1:0],
                           exp[jtag_pkg::IDCODE_WIDTH-1:0]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Scan wrappers and pin helpers
    //////////////////////////////////////////////////////////////////////

    task automatic run_ir_scan(input jtag_pkg::ir_opcode_e op);
        logic [jtag_pkg::IR_WIDTH-1:0] captured;
        scan_ir(op, captured);
        cur_kind = SCAN_IR;
        cur_len  = jtag_pkg::IR_WIDTH;
        cur_din  = 64'(op);
        cur_dout = 64'(captured);
        scans_issued++;
        -> scan_done;
    endtask

    task automatic run_dr_scan(input scan_kind_e kind, input int len, input logic [63:0] din);
        logic [63:0] dout;
        scan_dr(len, din, dout);
        cur_kind = kind;
        cur_len  = len;
        cur_din  = din;
        cur_dout = dout;
        scans_issued++;
        -> scan_done;
    endtask

    task automatic new_pins();
        @(negedge TCK);
        sys_in   = IN_W'($random(seed));
        core_out = OUT_W'($random(seed));
        bsr_snap = {sys_in, core_out};
    endtask

    task automatic check_pins(input logic [IN_W-1:0] exp_core_in,
                              input logic [OUT_W-1:0] exp_sys_out);
        #1;                                  // Let the muxes settle
        check_core_in(core_in, exp_core_in);
        check_sys_out(sys_out, exp_sys_out);
    endtask

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [63:0] pattern;
        logic        tdo_v;
        rst      = 1'b1;
        tms      = 1'b1;
        tdi      = 1'b0;
        sys_in   = '0;
        core_out = '0;
        bsr_snap = '0;
        repeat (3) @(posedge TCK);
        @(negedge TCK);
        rst = 1'b0;

        // Reset state, then IDCODE is the default instruction
        check_bit("tdo_en", tdo_en, 1'b0);
        check_bit("tdo", tdo, 1'b0);
        step_checked(1'b0, 1'b0, 1'b0, tdo_v);   // TLR to RTI
        new_pins();
        check_pins(sys_in, core_out);
        run_dr_scan(SCAN_IDCODE, 32, random_word());

        // BYPASS and an undefined code
        run_ir_scan(jtag_pkg::BYPASS);
        run_dr_scan(SCAN_BYPASS, 24, random_word());
        run_ir_scan(jtag_pkg::ir_opcode_e'(4'b0110));
        run_dr_scan(SCAN_BYPASS, 24, random_word());

        // SAMPLE_PRELOAD observes the pins
        run_ir_scan(jtag_pkg::SAMPLE_PRELOAD);
        new_pins();
        run_dr_scan(SCAN_BSR, BSR_W, random_word());
        check_pins(sys_in, core_out);

        // EXTEST drives sys_out from the preloaded output cells
        pattern = random_word();
        new_pins();
        run_dr_scan(SCAN_BSR, BSR_W, pattern);
        check_pins(sys_in, core_out);
        run_ir_scan(jtag_pkg::EXTEST);
        check_pins(sys_in, pattern[OUT_W-1:0]);
        new_pins();
        check_pins(sys_in, pattern[OUT_W-1:0]);
        pattern = random_word();
        run_dr_scan(SCAN_BSR, BSR_W, pattern);
        check_pins(sys_in, pattern[OUT_W-1:0]);  // New value right after update

        // INTEST drives core_in from the preloaded input cells
        run_ir_scan(jtag_pkg::SAMPLE_PRELOAD);
        pattern = random_word();
        run_dr_scan(SCAN_BSR, BSR_W, pattern);
        run_ir_scan(jtag_pkg::INTEST);
        check_pins(pattern[BSR_W-1:OUT_W], core_out);
        new_pins();
        check_pins(pattern[BSR_W-1:OUT_W], core_out);

        // Hold cells drive sys_out again before the reset
        run_ir_scan(jtag_pkg::EXTEST);
        check_pins(sys_in, pattern[OUT_W-1:0]);

        // Abandon a DR shift halfway through
        pattern = random_word();
        step_checked(1'b1, 1'b0, 1'b0, tdo_v);
        step_checked(1'b0, 1'b0, 1'b0, tdo_v);
        step_checked(1'b0, 1'b0, 1'b0, tdo_v);
        for (int i = 0; i < 5; i++) begin
            step_checked(1'b0, pattern[i], 1'b1, tdo_v);
        end
        goto_reset();
        new_pins();
        check_pins(sys_in, core_out);
        run_dr_scan(SCAN_IDCODE, 32, random_word());
        check_pins(sys_in, core_out);

        @(negedge TCK);                      // Compare process catches up
        if (scans_compared != scans_issued) begin
            errors++;
            $display("Compare process handled %0d of %0d scans", scans_compared, scans_issued);
        end
        $display("Checks: %0d  Errors: %0d  Scans: %0d", checks, errors, scans_issued);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(PLANNED_SCANS * SCAN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Checks: %0d  Errors: %0d  Scans: %0d", checks, errors, scans_issued);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- all.f
+incdir+verification
rtl/jtag_pkg.sv
rtl/tap_controller.sv
rtl/instruction_register.sv
rtl/boundary_scan_register.sv
rtl/idcode_bypass_tdo.sv
rtl/jtag_tap_top.sv
verification/tb_jtag_tap.sv

//--- Bender.yml
package:
  name: jtag_tap

sources:
  # RTL in compile order
  - rtl/jtag_pkg.sv
  - rtl/tap_controller.sv
  - rtl/instruction_register.sv
  - rtl/boundary_scan_register.sv
  - rtl/idcode_bypass_tdo.sv
  - rtl/jtag_tap_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_jtag_tap.sv
